// File: src/alu_pkg.sv
// Arithmetic unit definitions shared by the pipeline stages and the testbench.
// Data is unsigned 16 bits and every result wraps to that width.
// Opcode values equal the raw command bits, so 3'b111 is always ILLEGAL.
`default_nettype none

package alu_pkg;

   localparam int data_w  = 16;              // operand and result width.
   localparam int shamt_w = $clog2(data_w);  // only these low bits of b set the SLL shift.

   // The raw command code maps one to one onto these values.
   typedef enum logic [2:0] {
      ADD     = 3'b000,  // a + b, wraps at data_w bits.
      SUB     = 3'b001,  // a - b, wraps at data_w bits.
      AND     = 3'b010,
      OR      = 3'b011,
      XOR     = 3'b100,
      SLL     = 3'b101,  // a shifted left by b[shamt_w-1:0].
      MUL     = 3'b110,  // low data_w bits of a * b, computed over several cycles.
      ILLEGAL = 3'b111   // gives a zero result with err set.
   } alu_op_e;

   typedef struct packed {
      logic err;   // set only for ILLEGAL commands.
      logic neg;   // copy of the result's top bit.
      logic zero;  // high when the result is all zeros.
   } flags_t;

endpackage

`default_nettype wire

// File: src/pipe_pkg.sv
// Pipeline definitions for tags, multiply timing and stage payloads.
// The multiply runs one iteration per operand bit and holds its stage meanwhile.
// Payload layouts are packed, so widths are fixed at 39 and 21 bits.
`default_nettype none

package pipe_pkg;

   localparam int tag_w      = 4;                   // command tag, returned unchanged.
   localparam int mul_cycles = alu_pkg::data_w;     // one shift-add step per bit of b.
   localparam int cnt_w      = $clog2(mul_cycles);  // width of the iteration counter.

   // value of the iteration counter during the final multiply step.
   localparam logic [cnt_w-1:0] mul_last = cnt_w'(mul_cycles - 1);

   typedef struct packed {
      alu_pkg::alu_op_e            op;   // decoded opcode.
      logic [alu_pkg::data_w-1:0]  a;
      logic [alu_pkg::data_w-1:0]  b;
      logic [tag_w-1:0]            tag;
   } id_pl_t;

   typedef struct packed {
      logic [alu_pkg::data_w-1:0]  result;
      logic                        err;  // the command was ILLEGAL.
      logic [tag_w-1:0]            tag;
   } ex_pl_t;

endpackage

`default_nettype wire

// File: src/pipe_if.sv
// Valid/ready link between two pipeline stages, generic in its payload type.
// A transfer happens on a rising edge with valid and ready both high.
// The source keeps valid and pl stable until the transfer or a flush.
`timescale 1ns/1ps
`default_nettype none

interface pipe_if #(
   parameter type pl_t = logic  // payload struct carried by this link.
);

   logic valid;  // source has an item.
   logic ready;  // destination can take it.
   pl_t  pl;     // item contents, meaningful while valid is high.

   modport src (output valid, output pl, input ready);  // upstream stage.
   modport dst (input valid, input pl, output ready);   // downstream stage.

endinterface

`default_nettype wire

// File: src/hds_buf.sv
// One-slot handshake buffer that controls a stage's valid and ready.
// It tracks only occupancy. The owner stores the payload when p_ce pulses.
// Flush empties the slot, so an item pushed in the flush cycle is lost.
// With bypass set, ready depends combinationally on the downstream pop.
`timescale 1ns/1ps
`default_nettype none

module hds_buf #(
   parameter bit bypass = 1'b1  // a full slot may refill in the cycle it drains.
) (
   input  logic clk,
   input  logic rst_n,
   input  logic flush,
   input  logic a_en,     // allows a_ready to rise.
   input  logic a_valid,
   output logic a_ready,
   input  logic b_en,     // allows b_valid to rise.
   output logic b_valid,
   input  logic b_ready,
   output logic p_ce      // capture strobe for the owner's payload.
);

   logic push;         // input side transfer.
   logic pop;          // output side transfer.
   logic pending;      // slot holds an item.
   logic pending_nxt;

   assign push        = a_valid & a_ready;
   assign pop         = b_valid & b_ready;
   assign pending_nxt = (push | ~pop) & ~flush;  // a push wins over a pop, flush wins over both.

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pending <= 1'b0;
      end else if (push | pop | flush) begin
         pending <= pending_nxt;  // slot only changes on an event.
      end
   end

   assign b_valid = b_en & pending;

   generate
      if (bypass) begin : g_bypass
         assign a_ready = a_en & (~pending | pop);  // room now or room after this pop.
      end else begin : g_no_bypass
         assign a_ready = a_en & ~pending;
      end
   endgenerate

   assign p_ce = push;

endmodule

`default_nettype wire

// File: src/id_stage.sv
// First stage. It registers each incoming command and decodes its opcode.
// Any raw code without an operation decodes to ILLEGAL.
// in_ready follows the downstream ready through the bypass path.
`timescale 1ns/1ps
`default_nettype none

module id_stage (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         flush,
   input  logic                         in_valid,
   output logic                         in_ready,
   input  logic [2:0]                   in_op,     // raw opcode bits.
   input  logic [alu_pkg::data_w-1:0]   in_a,
   input  logic [alu_pkg::data_w-1:0]   in_b,
   input  logic [pipe_pkg::tag_w-1:0]   in_tag,
   pipe_if.src                          id_ex      // link to ex_stage.
);

   logic             cap;     // command accepted this cycle.
   alu_pkg::alu_op_e dec_op;  // decoded form of in_op.
   pipe_pkg::id_pl_t pl_q;    // held command.

   // The decode is written out so the enum never depends on a bare cast.
   always_comb begin
      case (in_op)
         3'b000:  dec_op = alu_pkg::ADD;
         3'b001:  dec_op = alu_pkg::SUB;
         3'b010:  dec_op = alu_pkg::AND;
         3'b011:  dec_op = alu_pkg::OR;
         3'b100:  dec_op = alu_pkg::XOR;
         3'b101:  dec_op = alu_pkg::SLL;
         3'b110:  dec_op = alu_pkg::MUL;
         default: dec_op = alu_pkg::ILLEGAL;  // 3'b111 has no operation.
      endcase
   end

   hds_buf u_buf (
      .clk     (clk),
      .rst_n   (rst_n),
      .flush   (flush),
      .a_en    (1'b1),         // decode never stalls on its own.
      .a_valid (in_valid),
      .a_ready (in_ready),
      .b_en    (1'b1),
      .b_valid (id_ex.valid),
      .b_ready (id_ex.ready),
      .p_ce    (cap)
   );

   always_ff @(posedge clk) begin
      if (cap) begin
         pl_q.op  <= dec_op;
         pl_q.a   <= in_a;
         pl_q.b   <= in_b;
         pl_q.tag <= in_tag;
      end
   end

   assign id_ex.pl = pl_q;

endmodule

`default_nettype wire

// File: src/ex_stage.sv
// Execute stage. Single-cycle operations are computed as the item is captured.
// MUL runs a shift-add loop for mul_cycles cycles and holds the stage meanwhile.
// valid stays low until the product is complete, and no new item enters.
// Flush aborts a running multiply and empties the stage.
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
   input  logic clk,
   input  logic rst_n,
   input  logic flush,
   pipe_if.dst  id_ex,  // from id_stage.
   pipe_if.src  ex_wb   // to wb_stage.
);

   typedef enum logic [1:0] {
      IDLE,     // no multiply pending, the slot may hold a single-cycle result.
      MUL_RUN,  // shift-add iterations in progress.
      DONE      // product is ready and waits for the pop.
   } mul_state_e;

   mul_state_e                        state;
   logic [pipe_pkg::cnt_w-1:0]        bit_cnt;  // index of the current multiply step.
   logic                              push;     // item captured from id_stage.
   logic                              pop;      // item handed to wb_stage.
   logic                              a_en;
   logic                              b_en;
   logic [alu_pkg::data_w-1:0]        alu_res;  // single-cycle result of the incoming item.
   logic [alu_pkg::data_w-1:0]        mcand;    // a, shifted left once per step.
   logic [alu_pkg::data_w-1:0]        mplier;   // b, shifted right once per step.
   pipe_pkg::ex_pl_t                  pl_q;     // result doubles as the product accumulator.

   assign a_en = (state == IDLE) || (state == DONE);  // no intake while the loop runs.
   assign b_en = (state != MUL_RUN);                  // hide the partial product.
   assign pop  = ex_wb.valid & ex_wb.ready;

   hds_buf u_buf (
      .clk     (clk),
      .rst_n   (rst_n),
      .flush   (flush),
      .a_en    (a_en),
      .a_valid (id_ex.valid),
      .a_ready (id_ex.ready),
      .b_en    (b_en),
      .b_valid (ex_wb.valid),
      .b_ready (ex_wb.ready),
      .p_ce    (push)
   );

   always_comb begin
      case (id_ex.pl.op)
         alu_pkg::ADD: alu_res = id_ex.pl.a + id_ex.pl.b;
         alu_pkg::SUB: alu_res = id_ex.pl.a - id_ex.pl.b;
         alu_pkg::AND: alu_res = id_ex.pl.a & id_ex.pl.b;
         alu_pkg::OR:  alu_res = id_ex.pl.a | id_ex.pl.b;
         alu_pkg::XOR: alu_res = id_ex.pl.a ^ id_ex.pl.b;
         alu_pkg::SLL: alu_res = id_ex.pl.a << id_ex.pl.b[alu_pkg::shamt_w-1:0];
         default:      alu_res = '0;  // MUL starts its sum here and ILLEGAL stays zero.
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= IDLE;
         bit_cnt <= '0;
      end else if (flush) begin
         state   <= IDLE;  // a running multiply is dropped.
         bit_cnt <= '0;
      end else if (push) begin
         state   <= (id_ex.pl.op == alu_pkg::MUL) ? MUL_RUN : IDLE;
         bit_cnt <= '0;
      end else if (state == MUL_RUN) begin
         bit_cnt <= bit_cnt + 1'b1;
         if (bit_cnt == pipe_pkg::mul_last) begin
            state <= DONE;  // last step lands in this edge.
         end
      end else if (pop) begin
         state <= IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         pl_q.result <= alu_res;
         pl_q.err    <= (id_ex.pl.op == alu_pkg::ILLEGAL);
         pl_q.tag    <= id_ex.pl.tag;
         mcand       <= id_ex.pl.a;
         mplier      <= id_ex.pl.b;
      end else if (state == MUL_RUN) begin
         if (mplier[0]) begin
            pl_q.result <= pl_q.result + mcand;  // bits above data_w fall away.
         end
         mcand  <= mcand << 1;
         mplier <= mplier >> 1;
      end
   end

   assign ex_wb.pl = pl_q;

endmodule

`default_nettype wire

// File: src/wb_stage.sv
// Write-back stage. It registers each result and presents it on the output port.
// zero and neg are derived from the held result, err comes with the payload.
// The item stays on the port while out_ready is low.
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         flush,
   pipe_if.dst                          ex_wb,       // from ex_stage.
   output logic                         out_valid,
   input  logic                         out_ready,
   output logic [alu_pkg::data_w-1:0]   out_result,
   output alu_pkg::flags_t              out_flags,
   output logic [pipe_pkg::tag_w-1:0]   out_tag
);

   logic                        cap;       // result accepted this cycle.
   logic [alu_pkg::data_w-1:0]  result_q;
   logic                        err_q;
   logic [pipe_pkg::tag_w-1:0]  tag_q;

   hds_buf u_buf (
      .clk     (clk),
      .rst_n   (rst_n),
      .flush   (flush),
      .a_en    (1'b1),
      .a_valid (ex_wb.valid),
      .a_ready (ex_wb.ready),
      .b_en    (1'b1),         // only out_ready can hold this stage.
      .b_valid (out_valid),
      .b_ready (out_ready),
      .p_ce    (cap)
   );

   always_ff @(posedge clk) begin
      if (cap) begin
         result_q <= ex_wb.pl.result;
         err_q    <= ex_wb.pl.err;
         tag_q    <= ex_wb.pl.tag;
      end
   end

   assign out_result = result_q;
   assign out_tag    = tag_q;
   assign out_flags  = '{err: err_q,
                         neg: result_q[alu_pkg::data_w-1],  // sign bit of the result.
                         zero: (result_q == '0)};

endmodule

`default_nettype wire

// File: src/alu_pipe_top.sv
// Top level of the three-stage arithmetic pipeline with plain ports.
// Up to three commands are in flight, and results leave in acceptance order.
// in_op carries raw opcode bits. Codes without an operation return err.
// in_ready depends combinationally on out_ready through the stage bypass.
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_top (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         flush,       // drops every item in flight.
   input  logic                         in_valid,
   output logic                         in_ready,
   input  logic [2:0]                   in_op,
   input  logic [alu_pkg::data_w-1:0]   in_a,
   input  logic [alu_pkg::data_w-1:0]   in_b,
   input  logic [pipe_pkg::tag_w-1:0]   in_tag,
   output logic                         out_valid,
   input  logic                         out_ready,
   output logic [alu_pkg::data_w-1:0]   out_result,
   output alu_pkg::flags_t              out_flags,
   output logic [pipe_pkg::tag_w-1:0]   out_tag
);

   pipe_if #(.pl_t(pipe_pkg::id_pl_t)) id_to_ex ();  // decoded commands.
   pipe_if #(.pl_t(pipe_pkg::ex_pl_t)) ex_to_wb ();  // computed results.

   id_stage u_id (
      .clk      (clk),
      .rst_n    (rst_n),
      .flush    (flush),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .in_op    (in_op),
      .in_a     (in_a),
      .in_b     (in_b),
      .in_tag   (in_tag),
      .id_ex    (id_to_ex.src)
   );

   ex_stage u_ex (
      .clk   (clk),
      .rst_n (rst_n),
      .flush (flush),
      .id_ex (id_to_ex.dst),
      .ex_wb (ex_to_wb.src)
   );

   wb_stage u_wb (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .ex_wb      (ex_to_wb.dst),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_result (out_result),
      .out_flags  (out_flags),
      .out_tag    (out_tag)
   );

endmodule

`default_nettype wire

// File: bench/clk_gen.sv
// Clock and reset source for the testbench.
// rst_n is low for reset_cycles rising edges and is released on a falling edge.
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
   parameter int period_ns    = 20,  // full clock period.
   parameter int reset_cycles = 2    // rising edges seen with rst_n low.
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(period_ns / 2) clk = ~clk;  // first rising edge at half a period.
   end

   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;  // released away from the sampling edge.
   end

endmodule

`default_nettype wire

// File: bench/alu_pipe_sva.sv
// Concurrent checks on the pipeline's top-level handshakes and flush.
// Only top-level ports are visible here, so the internal stage links are not checked.
// A stalled output may drop in the cycle after a flush, which the hold check allows.
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_sva (
   input logic                         clk,
   input logic                         rst_n,
   input logic                         flush,
   input logic                         in_ready,
   input logic                         out_valid,
   input logic                         out_ready,
   input logic [alu_pkg::data_w-1:0]   out_result,
   input alu_pkg::flags_t              out_flags,
   input logic [pipe_pkg::tag_w-1:0]   out_tag
);

   int fail_cnt = 0;  // number of failed checks, read by the testbench.

   // a stalled item keeps its place and contents until it is taken.
   property p_out_hold;
      @(posedge clk) disable iff (!rst_n)
         (out_valid && !out_ready && !flush) |=>
            (out_valid && $stable(out_result) && $stable(out_flags) && $stable(out_tag));
   endproperty

   property p_reset_state;
      @(posedge clk) $rose(rst_n) |-> (in_ready && !out_valid);  // empty pipe after reset.
   endproperty

   property p_flush_empty;
      @(posedge clk) disable iff (!rst_n) flush |=> !out_valid;  // wb slot is cleared.
   endproperty

   a_out_hold: assert property (p_out_hold) else begin
      fail_cnt++;
      $error("output item changed or vanished while out_ready was low");
   end

   a_reset_state: assert property (p_reset_state) else begin
      fail_cnt++;
      $error("pipeline not empty and ready in the first cycle after reset");
   end

   a_flush_empty: assert property (p_flush_empty) else begin
      fail_cnt++;
      $error("out_valid high in the cycle after a flush");
   end

endmodule

bind alu_pipe_top alu_pipe_sva u_sva (
   .clk        (clk),
   .rst_n      (rst_n),
   .flush      (flush),
   .in_ready   (in_ready),
   .out_valid  (out_valid),
   .out_ready  (out_ready),
   .out_result (out_result),
   .out_flags  (out_flags),
   .out_tag    (out_tag)
);

`default_nettype wire

// File: bench/tb_alu_pipe.sv
// Testbench for the three-stage arithmetic pipeline.
// Commands, back-pressure and flushes are random from a fixed seed.
// A queue model predicts each output in acceptance order and is cleared on flush.
// The run stops after n_cmds accepted commands, a full drain and a few idle cycles.
`timescale 1ns/1ps
`default_nettype none

module tb_alu_pipe;

   localparam int n_cmds     = 2000;                                   // commands to deliver.
   localparam int max_cycles = n_cmds * (3 + pipe_pkg::mul_cycles) + 200;  // worst case, drain.
   localparam logic [pipe_pkg::tag_w-1:0] tag_step = 1;

   typedef struct packed {
      logic [alu_pkg::data_w-1:0]  result;
      alu_pkg::flags_t             flags;
      logic [pipe_pkg::tag_w-1:0]  tag;
   } exp_t;

   logic                        clk;
   logic                        rst_n;
   logic                        flush;
   logic                        in_valid;
   logic                        in_ready;
   logic [2:0]                  in_op;
   logic [alu_pkg::data_w-1:0]  in_a;
   logic [alu_pkg::data_w-1:0]  in_b;
   logic [pipe_pkg::tag_w-1:0]  in_tag;
   logic                        out_valid;
   logic                        out_ready;
   logic [alu_pkg::data_w-1:0]  out_result;
   alu_pkg::flags_t             out_flags;
   logic [pipe_pkg::tag_w-1:0]  out_tag;

   exp_t exp_q[$];  // results still owed by the DUT, oldest first.
   int   seed;
   int   errors;
   int   n_in;      // commands accepted outside a flush cycle.
   int   n_out;     // outputs taken.
   int   n_flush;
   bit   in_fire;   // input transfer at the last rising edge.

   clk_gen #(.period_ns(20), .reset_cycles(2)) u_clk (.clk(clk), .rst_n(rst_n));

   alu_pipe_top DUT (
      .clk(clk), .rst_n(rst_n), .flush(flush),
      .in_valid(in_valid), .in_ready(in_ready), .in_op(in_op),
      .in_a(in_a), .in_b(in_b), .in_tag(in_tag),
      .out_valid(out_valid), .out_ready(out_ready), .out_result(out_result),
      .out_flags(out_flags), .out_tag(out_tag)
   );

   function automatic logic [31:0] next_rand();
      return $random(seed);
   endfunction

   function automatic bit roll(input int num, input int den);
      logic [31:0] r;
      r = next_rand();
      return (r % den) < num;  // true in num out of den cases.
   endfunction

   // result rules of the arithmetic unit, written from its definition.
   function automatic exp_t predict(input logic [2:0] op, input logic [alu_pkg::data_w-1:0] a,
                                    input logic [alu_pkg::data_w-1:0] b,
                                    input logic [pipe_pkg::tag_w-1:0] tag);
      logic [2*alu_pkg::data_w-1:0] prod;
      exp_t                         e;
      prod        = {{alu_pkg::data_w{1'b0}}, a} * {{alu_pkg::data_w{1'b0}}, b};
      e.tag       = tag;
      e.flags.err = 1'b0;
      case (op)
         alu_pkg::ADD: e.result = a + b;
         alu_pkg::SUB: e.result = a - b;
         alu_pkg::AND: e.result = a & b;
         alu_pkg::OR:  e.result = a | b;
         alu_pkg::XOR: e.result = a ^ b;
         alu_pkg::SLL: e.result = a << b[3:0];
         alu_pkg::MUL: e.result = prod[alu_pkg::data_w-1:0];  // low half of the product.
         default: begin
            e.result    = '0;
            e.flags.err = 1'b1;
         end
      endcase
      e.flags.zero = (e.result == '0);
      e.flags.neg  = e.result[alu_pkg::data_w-1];
      return e;
   endfunction

   task automatic check_result(input logic [alu_pkg::data_w-1:0] got,
                               input logic [alu_pkg::data_w-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch out_result: got 0x%h, expected 0x%h", got, exp);
      end
   endtask

   task automatic check_flags(input alu_pkg::flags_t got, input alu_pkg::flags_t exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch out_flags: got 0x%h, expected 0x%h", got, exp);
      end
   endtask

   task automatic check_tag(input logic [pipe_pkg::tag_w-1:0] got,
                            input logic [pipe_pkg::tag_w-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch out_tag: got 0x%h, expected 0x%h", got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   // called on a falling edge. A command that was not taken stays on the port.
   task automatic drive_inputs(input bit draining);
      logic [31:0] r_op;
      logic [31:0] r_ab;
      if (in_fire) begin
         in_tag = in_tag + tag_step;  // rolling tag, one step per transfer.
      end
      flush     = draining ? 1'b0 : roll(1, 60);
      out_ready = draining ? 1'b1 : roll(75, 100);
      if (draining) begin
         in_valid = 1'b0;
      end else if (!in_valid || in_fire) begin
         r_op     = next_rand();
         r_ab     = next_rand();
         in_valid = roll(70, 100);
         in_op    = r_op[2:0];  // raw 3'b111 included.
         in_a     = r_ab[31:16];
         in_b     = r_ab[15:0];
         if (r_op[6:3] == 4'd0) begin
            in_b = in_a;  // equal operands give zero results for SUB and XOR.
         end
      end
   endtask

   // called on a rising edge, before the DUT registers update.
   task automatic observe();
      exp_t e;
      in_fire = in_valid && in_ready;
      if (out_valid && out_ready) begin
         n_out++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("unexpected output with tag 0x%h while no result was owed", out_tag);
         end else begin
            e = exp_q.pop_front();
            check_result(out_result, e.result);
            check_flags(out_flags, e.flags);
            check_tag(out_tag, e.tag);
         end
      end
      if (flush) begin
         n_flush++;
         exp_q.delete();  // this cycle's output already counted, its input is dropped.
      end else if (in_fire) begin
         n_in++;
         exp_q.push_back(predict(in_op, in_a, in_b, in_tag));
      end
   endtask

   task automatic run_cycle(input bit draining);
      drive_inputs(draining);
      @(posedge clk);
      observe();
      @(negedge clk);
   endtask

   task automatic report_counts();
      $display("errors %0d, assertion failures %0d, accepted %0d, delivered %0d, flushes %0d",
               errors, DUT.u_sva.fail_cnt, n_in, n_out, n_flush);
   endtask

   initial begin : stimulus
      seed      = 32'hedff;
      errors    = 0;
      n_in      = 0;
      n_out     = 0;
      n_flush   = 0;
      in_fire   = 1'b0;
      flush     = 1'b0;
      in_valid  = 1'b0;
      in_op     = '0;
      in_a      = '0;
      in_b      = '0;
      in_tag    = '0;
      out_ready = 1'b0;
      wait (rst_n === 1'b1);  // released on a falling edge.
      check_bit("in_ready", in_ready, 1'b1);
      check_bit("out_valid", out_valid, 1'b0);
      while (n_in < n_cmds) begin
         run_cycle(1'b0);
      end
      while (exp_q.size() != 0) begin
         run_cycle(1'b1);  // drain with out_ready held high.
      end
      repeat (pipe_pkg::mul_cycles + 4) begin
         run_cycle(1'b1);  // any output now is unexpected.
      end
      report_counts();
      if (errors == 0 && DUT.u_sva.fail_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (max_cycles) @(posedge clk);
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      report_counts();
      $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
src/alu_pkg.sv
src/pipe_pkg.sv
src/pipe_if.sv
src/hds_buf.sv
src/id_stage.sv
src/ex_stage.sv
src/wb_stage.sv
src/alu_pipe_top.sv
bench/clk_gen.sv
bench/alu_pipe_sva.sv
bench/tb_alu_pipe.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_alu_pipe
FILELIST := compile.f
OBJ_DIR  := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
